// File: verilog/cpu_config.svh
/*
 * cpu configuration: data, address, memory and immediate sizes
 */

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and instruction word width
`define CPU_DATA_W 8

// program counter and memory address width
`define CPU_ADDR_W 4

// number of program bytes, one per address
`define CPU_MEM_DEPTH 16

// immediate operand, half a data word
`define CPU_NIBBLE_W 4

`endif

// File: verilog/cpu_pkg.sv
/*
 * cpu types: data words, addresses, opcodes, ALU ops and register selects
 */

`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0]   data_t;
  typedef logic [`CPU_ADDR_W-1:0]   addr_t;
  typedef logic [`CPU_NIBBLE_W-1:0] nibble_t;

  // opcode lives in instruction bits 7:4, codes C..F behave as NOP
  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_LDA_LO = 4'h1,
    OP_LDA_HI = 4'h2,
    OP_LDB_LO = 4'h3,
    OP_LDB_HI = 4'h4,
    OP_LDC_LO = 4'h5,
    OP_LDC_HI = 4'h6,
    OP_ADD    = 4'h7,
    OP_SUB    = 4'h8,
    OP_MUL    = 4'h9,
    OP_OUT    = 4'hA,
    OP_IN     = 4'hB
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_e;

endpackage

// File: verilog/cpu_ctrl_if.sv
/*
 * decoded control from the control unit to the register file
 */

interface cpu_ctrl_if;
  import cpu_pkg::*;

  // nibble loads into the register picked by imm_sel
  logic     ld_lo;
  logic     ld_hi;
  reg_sel_e imm_sel;
  nibble_t  imm;

  // full byte paths
  reg_sel_e in_sel;
  reg_sel_e out_sel;

  // ALU write back into C
  logic     alu_we;
  alu_op_e  alu_op;

  modport ctrl (
    output ld_lo, ld_hi, imm_sel, imm, in_sel, out_sel, alu_we, alu_op
  );

  modport regs (
    input ld_lo, ld_hi, imm_sel, imm, in_sel, out_sel, alu_we
  );

endinterface

// File: verilog/program_memory.sv
/*
 * program store, 16 bytes written by the host and read at the program counter
 */

`include "cpu_config.svh"

module program_memory (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             clear,
  input  logic [1:0]       mode,
  input  cpu_pkg::addr_t   addr,
  input  cpu_pkg::data_t   wdata,
  input  cpu_pkg::addr_t   pc,
  output cpu_pkg::data_t   instr
);
  import cpu_pkg::*;

  localparam logic [1:0] MODE_WRITE = 2'b01;

  data_t mem [`CPU_MEM_DEPTH];
  logic  wr_en;

  //////////////////////////////
  // host write port
  //////////////////////////////

  // only the 01 pattern of the mode field writes
  assign wr_en = (mode == MODE_WRITE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (clear) begin
      // clear wins over a write on the same edge
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  //////////////////////////////
  // fetch
  //////////////////////////////

  // asynchronous read, the decoder sees the byte in the same cycle
  assign instr = mem[pc];

  // the reserved 11 mode pattern is only legal alongside clear
  mode_reserved_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    (mode == 2'b11) |-> clear
  );

endmodule

// File: verilog/control_unit.sv
/*
 * program counter and instruction decoder, one instruction per clock while running
 */

module control_unit (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           run,
  input  logic           clear,
  input  cpu_pkg::data_t instr,
  output cpu_pkg::addr_t pc,
  cpu_ctrl_if.ctrl       ctl
);
  import cpu_pkg::*;

  opcode_e opcode;
  nibble_t operand;

  // IN and OUT operand 0..2 picks A..C, anything else is ignored
  function automatic reg_sel_e operand_sel(nibble_t op);
    case (op)
      4'd0:    return REG_A;
      4'd1:    return REG_B;
      4'd2:    return REG_C;
      default: return REG_NONE;
    endcase
  endfunction

  //////////////////////////////
  // program counter
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (clear) begin
      pc <= '0;
    end else if (run) begin
      // wraps from 15 back to 0
      pc <= pc + 1'b1;
    end
  end

  //////////////////////////////
  // decode
  //////////////////////////////

  assign opcode  = opcode_e'(instr[7:4]);
  assign operand = instr[3:0];

  always_comb begin
    ctl.ld_lo   = 1'b0;
    ctl.ld_hi   = 1'b0;
    ctl.imm_sel = REG_NONE;
    ctl.imm     = operand;
    ctl.in_sel  = REG_NONE;
    ctl.out_sel = REG_NONE;
    ctl.alu_we  = 1'b0;
    ctl.alu_op  = ALU_ADD;

    // strobes only fire while running
    if (run) begin
      case (opcode)
        OP_LDA_LO: begin ctl.ld_lo = 1'b1; ctl.imm_sel = REG_A; end
        OP_LDA_HI: begin ctl.ld_hi = 1'b1; ctl.imm_sel = REG_A; end
        OP_LDB_LO: begin ctl.ld_lo = 1'b1; ctl.imm_sel = REG_B; end
        OP_LDB_HI: begin ctl.ld_hi = 1'b1; ctl.imm_sel = REG_B; end
        OP_LDC_LO: begin ctl.ld_lo = 1'b1; ctl.imm_sel = REG_C; end
        OP_LDC_HI: begin ctl.ld_hi = 1'b1; ctl.imm_sel = REG_C; end
        OP_ADD:    begin ctl.alu_we = 1'b1; ctl.alu_op = ALU_ADD; end
        OP_SUB:    begin ctl.alu_we = 1'b1; ctl.alu_op = ALU_SUB; end
        OP_MUL:    begin ctl.alu_we = 1'b1; ctl.alu_op = ALU_MUL; end
        OP_OUT:    ctl.out_sel = operand_sel(operand);
        OP_IN:     ctl.in_sel  = operand_sel(operand);
        // NOP and the unused codes C..F
        default: ;
      endcase
    end
  end

  // one register action per retired instruction
  single_action_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({ctl.ld_lo, ctl.ld_hi, ctl.alu_we,
              ctl.in_sel != REG_NONE, ctl.out_sel != REG_NONE})
  );

endmodule

// File: verilog/register_file.sv
/*
 * registers A, B, C and the output register with their load paths
 */

`include "cpu_config.svh"

module register_file (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           clear,
  input  cpu_pkg::data_t ui_in,
  cpu_ctrl_if.regs       ctl,
  input  cpu_pkg::data_t result,
  output cpu_pkg::data_t a,
  output cpu_pkg::data_t b,
  output cpu_pkg::data_t uo_out
);
  import cpu_pkg::*;

  data_t reg_a, reg_b, reg_c, reg_out;
  data_t a_nxt, b_nxt, c_nxt, out_nxt;

  // replace one half of a register and keep the other
  function automatic data_t merge_nibble(data_t cur, nibble_t nib, logic hi);
    if (hi) begin
      return {nib, cur[`CPU_NIBBLE_W-1:0]};
    end
    return {cur[`CPU_DATA_W-1:`CPU_NIBBLE_W], nib};
  endfunction

  //////////////////////////////
  // next state selection
  //////////////////////////////

  always_comb begin
    a_nxt = reg_a;
    b_nxt = reg_b;
    c_nxt = reg_c;

    if (ctl.ld_lo || ctl.ld_hi) begin
      case (ctl.imm_sel)
        REG_A:   a_nxt = merge_nibble(reg_a, ctl.imm, ctl.ld_hi);
        REG_B:   b_nxt = merge_nibble(reg_b, ctl.imm, ctl.ld_hi);
        REG_C:   c_nxt = merge_nibble(reg_c, ctl.imm, ctl.ld_hi);
        default: ;
      endcase
    end

    // IN takes the whole input byte
    case (ctl.in_sel)
      REG_A:   a_nxt = ui_in;
      REG_B:   b_nxt = ui_in;
      REG_C:   c_nxt = ui_in;
      default: ;
    endcase

    if (ctl.alu_we) begin
      c_nxt = result;
    end
  end

  always_comb begin
    case (ctl.out_sel)
      REG_A:   out_nxt = reg_a;
      REG_B:   out_nxt = reg_b;
      REG_C:   out_nxt = reg_c;
      default: out_nxt = reg_out;
    endcase
  end

  //////////////////////////////
  // state
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a   <= '0;
      reg_b   <= '0;
      reg_c   <= '0;
      reg_out <= '0;
    end else if (clear) begin
      reg_a   <= '0;
      reg_b   <= '0;
      reg_c   <= '0;
      reg_out <= '0;
    end else begin
      reg_a   <= a_nxt;
      reg_b   <= b_nxt;
      reg_c   <= c_nxt;
      reg_out <= out_nxt;
    end
  end

  assign a      = reg_a;
  assign b      = reg_b;
  assign uo_out = reg_out;

  // the pins only move after an OUT or a clear on the previous edge
  out_stable_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    (uo_out != $past(uo_out)) |-> ($past(ctl.out_sel) != REG_NONE || $past(clear))
  );

endmodule

// File: verilog/alu.sv
/*
 * ALU: add, subtract and multiply of A and B, modulo 256
 */

module alu (
  input  cpu_pkg::data_t  a,
  input  cpu_pkg::data_t  b,
  input  cpu_pkg::alu_op_e op,
  output cpu_pkg::data_t  result
);
  import cpu_pkg::*;

  //////////////////////////////
  // operation select
  //////////////////////////////

  // all results are truncated to the data width
  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        // two's complement wrap below zero
        result = a - b;
      end
      ALU_MUL: begin
        // low byte of the product only
        result = a * b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: verilog/cpu_top.sv
/*
 * 8-bit accumulator cpu top, splits the host control byte and connects the blocks
 */

`include "cpu_config.svh"

module cpu_top (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::data_t ui_in,
  input  cpu_pkg::data_t uio_in,
  output cpu_pkg::data_t uo_out
);
  import cpu_pkg::*;

  logic       run;
  logic       clear;
  logic [1:0] mode;
  addr_t      wr_addr;

  addr_t pc;
  data_t instr;
  data_t reg_a;
  data_t reg_b;
  data_t alu_result;

  //////////////////////////////
  // host control byte
  //////////////////////////////

  // bit 7 run, bit 6 clear_n, bits 5:4 mode, low bits write address
  assign run     = uio_in[7];
  assign clear   = ~uio_in[6];
  assign mode    = uio_in[5:4];
  assign wr_addr = uio_in[`CPU_ADDR_W-1:0];

  cpu_ctrl_if ctl_if ();

  program_memory u_program_memory (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (clear),
    .mode   (mode),
    .addr   (wr_addr),
    .wdata  (ui_in),
    .pc     (pc),
    .instr  (instr)
  );

  control_unit u_control_unit (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (run),
    .clear  (clear),
    .instr  (instr),
    .pc     (pc),
    .ctl    (ctl_if.ctrl)
  );

  register_file u_register_file (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (clear),
    .ui_in  (ui_in),
    .ctl    (ctl_if.regs),
    .result (alu_result),
    .a      (reg_a),
    .b      (reg_b),
    .uo_out (uo_out)
  );

  alu u_alu (
    .a      (reg_a),
    .b      (reg_b),
    .op     (ctl_if.alu_op),
    .result (alu_result)
  );

endmodule

// File: verification/tb_cpu.sv
/*
 * testbench for the 8-bit cpu, runs the stim file programs and random ALU programs
 */

module tb_cpu;

  localparam int MAX_TESTS = 32;
  localparam int ALU_TESTS = 9;

  logic       clk;
  logic       arst_n;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;

  // programs from the stim file
  logic [7:0] file_prog [MAX_TESTS][16];
  logic [7:0] file_in [MAX_TESTS];
  logic [7:0] file_exp [MAX_TESTS];
  int         file_count;

  logic [7:0] cur_prog [16];
  int         seed;
  int         tests_run;
  int         tests_failed;
  int         errors;
  bit         test_ok;
  int         watchdog_cycles;
  logic       watchdog_armed = 1'b0;

  cpu_top dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .uo_out (uo_out)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout after %0d clock cycles, the tests did not finish", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // host port sequences
  //////////////////////////////

  // control byte: run, clear_n, mode, address
  task automatic drive(input logic [7:0] ctl_byte, input logic [7:0] data);
    @(posedge clk);
    uio_in <= ctl_byte;
    ui_in  <= data;
  endtask

  task automatic pulse_clear;
    drive(8'h00, 8'h00);
    drive(8'h40, 8'h00);
  endtask

  task automatic write_program;
    for (int i = 0; i < 16; i++) begin
      drive({4'h5, 4'(i)}, cur_prog[i]);
    end
  endtask

  // run high for exactly 16 edges, then sample between edges
  task automatic run_cycles(input logic [7:0] in_val);
    drive(8'hC0, in_val);
    repeat (15) @(posedge clk);
    drive(8'h40, in_val);
    @(negedge clk);
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic check_out(input logic [7:0] expected);
    assert (uo_out == expected) else begin
      $display("Error: uo_out = %h, expected %h", uo_out, expected);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_ok) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  task automatic program_test(input logic [7:0] in_val, input logic [7:0] expected,
                              input string name);
    test_ok = 1'b1;
    pulse_clear();
    write_program();
    run_cycles(in_val);
    check_out(expected);
    finish_test(name);
  endtask

  // reference results, everything modulo 256
  function automatic logic [7:0] alu_model(input logic [3:0] opcode, input logic [7:0] a,
                                           input logic [7:0] b);
    case (opcode)
      4'h7:    return a + b;
      4'h8:    return a - b;
      default: return a * b;
    endcase
  endfunction

  task automatic alu_test(input logic [3:0] opcode, input string op_name);
    logic [7:0] a;
    logic [7:0] b;
    a = 8'($random(seed));
    b = 8'($random(seed));
    for (int i = 0; i < 16; i++) begin
      cur_prog[i] = 8'h00;
    end
    cur_prog[0] = {4'h1, a[3:0]};
    cur_prog[1] = {4'h2, a[7:4]};
    cur_prog[2] = {4'h3, b[3:0]};
    cur_prog[3] = {4'h4, b[7:4]};
    cur_prog[4] = {opcode, 4'h0};
    cur_prog[5] = 8'hA2;
    program_test(8'h00, alu_model(opcode, a, b), $sformatf("%s a=%h b=%h", op_name, a, b));
  endtask

  // a stopped program must not touch the pins, clear must zero them
  task automatic halt_test;
    test_ok = 1'b1;
    for (int i = 0; i < 16; i++) begin
      cur_prog[i] = 8'h00;
    end
    cur_prog[0] = 8'h1E;
    cur_prog[1] = 8'h27;
    cur_prog[2] = 8'hA0;
    pulse_clear();
    write_program();
    run_cycles(8'h00);
    check_out(8'h7E);
    cur_prog[0] = 8'h19;
    cur_prog[1] = 8'h2F;
    write_program();
    drive(8'h40, 8'h00);
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_out(8'h7E);
    drive(8'h00, 8'h00);
    drive(8'h40, 8'h00);
    @(negedge clk);
    check_out(8'h00);
    finish_test("halt then clear");
  endtask

  task automatic read_stim;
    int         fd;
    int         n;
    string      line;
    logic [7:0] p [16];
    logic [7:0] in_val;
    logic [7:0] exp_val;
    fd = $fopen("verification/cpu_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/cpu_stim.txt, no stim programs were run");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    p[0], p[1], p[2], p[3], p[4], p[5], p[6], p[7],
                    p[8], p[9], p[10], p[11], p[12], p[13], p[14], p[15],
                    in_val, exp_val);
        if (n == 18 && file_count < MAX_TESTS) begin
          for (int i = 0; i < 16; i++) begin
            file_prog[file_count][i] = p[i];
          end
          file_in[file_count]  = in_val;
          file_exp[file_count] = exp_val;
          file_count++;
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    seed         = 78;
    file_count   = 0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    arst_n       = 1'b0;
    ui_in        = 8'h00;
    uio_in       = 8'h40;

    read_stim();
    // reset, stim lines, ALU programs and the halt test, about 40 cycles each
    watchdog_cycles = (file_count + ALU_TESTS + 2) * 40 + 100;
    watchdog_armed  = 1'b1;

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    test_ok = 1'b1;
    check_out(8'h00);
    finish_test("after reset");

    for (int t = 0; t < file_count; t++) begin
      for (int i = 0; i < 16; i++) begin
        cur_prog[i] = file_prog[t][i];
      end
      program_test(file_in[t], file_exp[t], $sformatf("stim line %0d", t));
    end

    for (int k = 0; k < ALU_TESTS; k++) begin
      case (k % 3)
        0:       alu_test(4'h7, "add");
        1:       alu_test(4'h8, "sub");
        default: alu_test(4'h9, "mul");
      endcase
    end

    halt_test();

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verification/cpu_stim.txt
# columns: 16 program bytes for addresses 0..15, ui_in, expected uo_out (all hex)
# one test per line, lines starting with # are skipped
# empty program
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
# nibble loads keep the other half, A then B then C
1F 2C 1A A0 00 00 00 00 00 00 00 00 00 00 00 00 00 CA
37 45 3E A1 00 00 00 00 00 00 00 00 00 00 00 00 00 5E
59 6B 53 A2 00 00 00 00 00 00 00 00 00 00 00 00 00 B3
# the last OUT decides the pins
1F 2F 3A 4A A0 A1 00 00 00 00 00 00 00 00 00 00 00 AA
# IN B then OUT B
B1 A1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 3C 3C
# IN and OUT with operand 3 or more do nothing
3A 45 B3 BF A1 A3 AF 00 00 00 00 00 00 00 00 00 FF 5A
# unused opcodes C..F and NOP
1D 25 A0 C1 D2 E3 F4 00 C0 FF A0 00 00 00 00 00 77 5D
37 A1 F0 F1 E2 D0 C1 A1 00 00 00 00 00 00 00 00 99 07
# ALU into C, subtract wraps, multiply keeps the low byte
13 22 35 40 70 A2 00 00 00 00 00 00 00 00 00 00 00 28
13 35 80 A2 00 00 00 00 00 00 00 00 00 00 00 00 00 FE
10 21 31 41 90 A2 00 00 00 00 00 00 00 00 00 00 00 10
# ALU result stays in C until OUT C
13 33 70 A0 00 00 00 00 00 00 00 00 00 00 00 00 00 03

// File: project.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_ctrl_if.sv
verilog/program_memory.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/cpu_top.sv
verification/tb_cpu.sv

// File: Makefile
# Verilator build and run of the cpu testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_cpu -f project.f -Mdir obj_dir

# the exit status comes from the search for the pass line
run: compile
	./obj_dir/Vtb_cpu | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null

clean:
	rm -rf obj_dir
